// File: test/ex_stimulus.txt
# kind class ctrl rd rj rk imm pc pred_taken pred_target exp_wb exp_data exp_taken
# exp_redirect exp_redirect_pc exp_fwd(j,k)   kind: 0 gap, 1 back to back, 2/3 counter
0 1 01 01 00 00 00000005 00000100 0 00000000 1 00000005 0 0 00000000 0
1 1 09 02 00 00 fffffff0 00000104 0 00000000 1 fffffff0 0 0 00000000 0
1 1 10 03 01 02 00000000 00000108 0 00000000 1 00000015 0 0 00000000 1
0 1 20 04 02 01 00000000 0000010c 0 00000000 1 00000001 0 0 00000000 0
0 1 30 05 02 01 00000000 00000110 0 00000000 1 00000000 0 0 00000000 0
0 1 40 06 02 03 00000000 00000114 0 00000000 1 00000010 0 0 00000000 0
0 1 50 07 01 03 00000000 00000118 0 00000000 1 00000015 0 0 00000000 0
0 1 60 08 01 03 00000000 0000011c 0 00000000 1 00000010 0 0 00000000 0
0 1 70 09 01 00 00000000 00000120 0 00000000 1 fffffffa 0 0 00000000 0
0 1 81 0a 02 00 00000024 00000124 0 00000000 1 ffffff00 0 0 00000000 0
1 1 91 0b 0a 00 00000008 00000128 0 00000000 1 00ffffff 0 0 00000000 2
1 1 a0 0c 0a 01 00000000 0000012c 0 00000000 1 fffffff8 0 0 00000000 0
0 1 b1 0d 00 00 12345000 00000130 0 00000000 1 12345000 0 0 00000000 0
0 1 01 00 01 00 00000007 00000134 0 00000000 0 00000000 0 0 00000000 0
1 1 00 0e 00 00 00000000 00000138 0 00000000 1 00000000 0 0 00000000 0
0 1 05 0f 00 00 00000010 00001000 0 00000000 1 00001010 0 0 00000000 0
0 2 00 00 08 06 00000040 00002000 1 00002040 0 00000000 1 0 00000000 0
0 2 20 00 01 01 00000080 00002100 1 00002180 0 00000000 0 1 00002104 0
0 2 40 00 02 01 fffffff0 00002200 0 00000000 0 00000000 1 1 000021f0 0
0 2 60 00 02 01 00000040 00002204 0 00000000 0 00000000 0 0 00000000 0
0 2 80 00 01 02 00000100 00002300 1 00002404 0 00000000 1 1 00002400 0
0 2 a0 00 01 02 00000100 00002304 0 00000000 0 00000000 0 0 00000000 0
0 2 d0 01 00 00 00000800 00003000 1 00003800 1 00003004 1 0 00000000 0
1 2 e0 00 01 00 00000010 00004000 0 00000000 0 00000000 1 1 00003014 2
2 1 0a 10 00 00 00000000 00004004 0 00000000 1 00000000 0 0 00000000 0
3 1 0a 11 00 00 00000000 00004008 0 00000000 1 00000000 0 0 00000000 0
2 1 0a 12 00 00 00000000 0000400c 0 00000000 1 00000000 0 0 00000000 0

// File: list.f
hdl/ex_pkg.sv
hdl/ex_regfile.sv
hdl/ex_forward.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_wb_reg.sv
hdl/ex_stage.sv
test/ex_stage_checker.sv
test/ex_stage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ex_stage_tb \
    -f list.f --Mdir obj_dir -o ex_stage_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/ex_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// File: test/ex_stage_tb.sv
`timescale 1ns/100ps
module ex_stage_tb import ex_pkg::*; ();

    logic              aclk = 1'b0;
    logic              aresetn;
    logic              uop_valid;
    op_class_e         uop_class;
    uop_ctrl_u         uop_ctrl;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rk;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc;
    logic              pred_taken;
    logic [XLEN-1:0]   pred_target;
    logic              wb_valid;
    logic [REG_AW-1:0] wb_rd;
    logic [XLEN-1:0]   wb_data;
    logic              fwd_j;
    logic              fwd_k;
    logic              fact_taken;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;

    int errors = 0;
    int ntests = 0;
    int cyc = 0;

    // result still owed by the last micro-op
    logic        pend;
    logic [31:0] pend_kind;
    logic [31:0] pend_wb;
    logic [31:0] pend_rd;
    logic [31:0] pend_data;
    int          pend_err;
    int          pend_idx;
    logic [31:0] last_cnt = '0;

    ex_stage #(
        .TID_VALUE (32'h0000_0001),
        .COUNTER_W (64)
    ) dut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .uop_valid_i   (uop_valid),
        .uop_class_i   (uop_class),
        .uop_ctrl_i    (uop_ctrl),
        .rd_i          (rd),
        .rj_i          (rj),
        .rk_i          (rk),
        .imm_i         (imm),
        .pc_i          (pc),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .wb_valid_o    (wb_valid),
        .wb_rd_o       (wb_rd),
        .wb_data_o     (wb_data),
        .forward_j_o   (fwd_j),
        .forward_k_o   (fwd_k),
        .fact_taken_o  (fact_taken),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    always #20 aclk = ~aclk;

    // cycles since reset match the stable counter
    always @(posedge aclk) begin
        if (aresetn) begin
            cyc <= cyc + 1;
        end
        if (cyc > 2000) begin
            $display("timeout: the run did not finish in time");
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // wait for the next falling edge and settle the owed writeback
    task automatic step;
        @(negedge aclk);
        if (pend) begin
            compare("wb_valid_o", pend_wb, {31'b0, wb_valid});
            if (pend_wb != 0) begin
                compare("wb_rd_o", pend_rd, {27'b0, wb_rd});
                if (pend_kind == 3) begin
                    if (wb_data <= last_cnt) begin
                        $display("counter value did not increase at t=%0t", $time);
                        errors++;
                    end
                end else begin
                    compare("wb_data_o", pend_data, wb_data);
                end
                if (pend_kind >= 2) begin
                    last_cnt = wb_data;
                end
            end
            if (errors == pend_err) begin
                $display("test %0d ok", pend_idx);
            end else begin
                $display("test %0d failed", pend_idx);
            end
            pend = 1'b0;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          gap;
        string       line;
        logic [31:0] kind;
        logic [31:0] cls;
        logic [31:0] ctl;
        logic [31:0] frd;
        logic [31:0] frj;
        logic [31:0] frk;
        logic [31:0] fimm;
        logic [31:0] fpc;
        logic [31:0] fpt;
        logic [31:0] fptg;
        logic [31:0] fwb;
        logic [31:0] fdata;
        logic [31:0] ftk;
        logic [31:0] frdr;
        logic [31:0] frpc;
        logic [31:0] ffwd;

        void'($urandom(95943));
        aresetn     = 1'b0;
        uop_valid   = 1'b0;
        uop_class   = OP_NOP;
        uop_ctrl    = '0;
        rd          = '0;
        rj          = '0;
        rk          = '0;
        imm         = '0;
        pc          = '0;
        pred_taken  = 1'b0;
        pred_target = '0;
        pend        = 1'b0;
        repeat (5) @(negedge aclk);
        aresetn = 1'b1;

        fd = $fopen("test/ex_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("*** FAILED ***");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) continue;
                if (line.len() < 8 || line[0] == "#") continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            kind, cls, ctl, frd, frj, frk, fimm, fpc,
                            fpt, fptg, fwb, fdata, ftk, frdr, frpc, ffwd);
                if (n != 16) begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                    continue;
                end
                if (kind == 0 || kind == 3) begin
                    gap = 1 + ($urandom % 3);
                    repeat (gap) begin
                        step();
                        uop_valid = 1'b0;
                    end
                end
                step();
                ntests++;
                uop_valid   = 1'b1;
                uop_class   = op_class_e'(cls[1:0]);
                uop_ctrl    = ctl[7:0];
                rd          = frd[4:0];
                rj          = frj[4:0];
                rk          = frk[4:0];
                imm         = fimm;
                pc          = fpc;
                pred_taken  = fpt[0];
                pred_target = fptg;
                pend_err    = errors;
                pend_idx    = ntests;
                pend_kind   = kind;
                pend_wb     = fwb;
                pend_rd     = frd;
                // counter reads predicted from the cycle count
                pend_data   = (kind == 2) ? cyc : fdata;
                #10;
                compare("fact_taken_o", ftk, {31'b0, fact_taken});
                compare("redirect_o", frdr, {31'b0, redirect});
                if (frdr != 0) begin
                    compare("redirect_pc_o", frpc, redirect_pc);
                end
                if (kind < 2) begin
                    compare("forward_jk", ffwd, {30'b0, fwd_j, fwd_k});
                end
                pend = 1'b1;
            end
            $fclose(fd);
            step();
            uop_valid = 1'b0;
            step();
            $display("tests %0d, errors %0d", ntests, errors);
            if (errors == 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: test/ex_stage_checker.sv
`timescale 1ns/100ps
module ex_stage_checker import ex_pkg::*; (
    input logic              aclk,
    input logic              aresetn,
    input logic              uop_valid_i,
    input logic              wb_valid_o,
    input logic [REG_AW-1:0] wb_rd_o,
    input logic              redirect_o
);

    // buffer comes out of reset empty
    assert property (@(posedge aclk) !aresetn |=> !wb_valid_o)
        else $error("wb_valid_o high in the cycle after reset");

    assert property (@(posedge aclk) disable iff (!aresetn) wb_valid_o |-> (wb_rd_o != '0))
        else $error("buffer holds a write to r0");

    // redirect only for a valid branch
    assert property (@(posedge aclk) disable iff (!aresetn) !uop_valid_i |-> !redirect_o)
        else $error("redirect_o high without a valid micro-op");

endmodule

bind ex_stage ex_stage_checker u_checker (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .uop_valid_i (uop_valid_i),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .redirect_o  (redirect_o)
);

// File: hdl/ex_stage.sv
`timescale 1ns/100ps
module ex_stage import ex_pkg::*; #(
    parameter logic [XLEN-1:0] TID_VALUE = '0,
    parameter int              COUNTER_W = 64
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              uop_valid_i,
    input  op_class_e         uop_class_i,
    input  uop_ctrl_u         uop_ctrl_i,
    input  logic [REG_AW-1:0] rd_i,
    input  logic [REG_AW-1:0] rj_i,
    input  logic [REG_AW-1:0] rk_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic              pred_taken_i,
    input  logic [XLEN-1:0]   pred_target_i,
    output logic              wb_valid_o,
    output logic [REG_AW-1:0] wb_rd_o,
    output logic [XLEN-1:0]   wb_data_o,
    output logic              forward_j_o,
    output logic              forward_k_o,
    output logic              fact_taken_o,
    output logic              redirect_o,
    output logic [XLEN-1:0]   redirect_pc_o
);

    logic [XLEN-1:0] rf_j_data;
    logic [XLEN-1:0] rf_k_data;
    logic [XLEN-1:0] rj_val;
    logic [XLEN-1:0] rk_val;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] link_pc;
    logic [XLEN-1:0] ex_result;
    logic            is_branch;
    logic            is_link;
    logic            ex_we;

    assign is_branch = (uop_class_i == OP_BRANCH);
    assign is_link   = is_branch && uop_ctrl_i.br.link;

    // writes to r0 never enter the buffer
    assign ex_we     = uop_valid_i && ((uop_class_i == OP_ALU) || is_link) && (rd_i != '0);
    assign ex_result = is_link ? link_pc : alu_result;

    ex_regfile u_regfile (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .ra_i      (rj_i),
        .rb_i      (rk_i),
        .rdata_a_o (rf_j_data),
        .rdata_b_o (rf_k_data),
        .we_i      (wb_valid_o),
        .wa_i      (wb_rd_o),
        .wd_i      (wb_data_o)
    );

    ex_forward u_forward_j (
        .rs_i       (rj_i),
        .rf_data_i  (rf_j_data),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .data_o     (rj_val),
        .fwd_o      (forward_j_o)
    );

    ex_forward u_forward_k (
        .rs_i       (rk_i),
        .rf_data_i  (rf_k_data),
        .wb_valid_i (wb_valid_o),
        .wb_rd_i    (wb_rd_o),
        .wb_data_i  (wb_data_o),
        .data_o     (rk_val),
        .fwd_o      (forward_k_o)
    );

    ex_alu #(
        .TID_VALUE (TID_VALUE),
        .COUNTER_W (COUNTER_W)
    ) u_alu (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .ctrl_i   (uop_ctrl_i),
        .rj_val_i (rj_val),
        .rk_val_i (rk_val),
        .pc_i     (pc_i),
        .imm_i    (imm_i),
        .result_o (alu_result)
    );

    ex_branch u_branch (
        .valid_i       (uop_valid_i),
        .is_branch_i   (is_branch),
        .ctrl_i        (uop_ctrl_i),
        .rj_val_i      (rj_val),
        .rk_val_i      (rk_val),
        .pc_i          (pc_i),
        .imm_i         (imm_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .taken_o       (fact_taken_o),
        .link_pc_o     (link_pc),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    ex_wb_reg u_wb_reg (
        .aclk    (aclk),
        .aresetn (aresetn),
        .we_i    (ex_we),
        .rd_i    (rd_i),
        .data_i  (ex_result),
        .valid_o (wb_valid_o),
        .rd_o    (wb_rd_o),
        .data_o  (wb_data_o)
    );

endmodule

// File: hdl/ex_wb_reg.sv
`timescale 1ns/100ps
module ex_wb_reg import ex_pkg::*; (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              we_i,
    input  logic [REG_AW-1:0] rd_i,
    input  logic [XLEN-1:0]   data_i,
    output logic              valid_o,
    output logic [REG_AW-1:0] rd_o,
    output logic [XLEN-1:0]   data_o
);

    logic              valid_q;
    logic [REG_AW-1:0] rd_q;
    logic [XLEN-1:0]   data_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= we_i;
        end
    end

    // payload follows the strobe every cycle
    always_ff @(posedge aclk) begin
        rd_q   <= rd_i;
        data_q <= data_i;
    end

    assign valid_o = valid_q;
    assign rd_o    = rd_q;
    assign data_o  = data_q;

endmodule

// File: hdl/ex_branch.sv
`timescale 1ns/100ps
module ex_branch import ex_pkg::*; (
    input  logic            valid_i,
    input  logic            is_branch_i,
    input  uop_ctrl_u       ctrl_i,
    input  logic [XLEN-1:0] rj_val_i,
    input  logic [XLEN-1:0] rk_val_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic            pred_taken_i,
    input  logic [XLEN-1:0] pred_target_i,
    output logic            taken_o,
    output logic [XLEN-1:0] link_pc_o,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o
);

    logic            active;
    logic            cond_true;
    logic [XLEN-1:0] target;

    assign active = valid_i && is_branch_i;

    always_comb begin
        case (ctrl_i.br.cond)
            BR_EQ:   cond_true = (rj_val_i == rk_val_i);
            BR_NE:   cond_true = (rj_val_i != rk_val_i);
            BR_LT:   cond_true = ($signed(rj_val_i) < $signed(rk_val_i));
            BR_GE:   cond_true = ($signed(rj_val_i) >= $signed(rk_val_i));
            BR_LTU:  cond_true = (rj_val_i < rk_val_i);
            BR_GEU:  cond_true = (rj_val_i >= rk_val_i);
            default: cond_true = 1'b1;
        endcase
    end

    // jirl is register relative and everything else pc relative
    assign target    = ((ctrl_i.br.cond == BR_JIRL) ? rj_val_i : pc_i) + imm_i;
    assign link_pc_o = pc_i + 32'd4;

    assign taken_o = active && cond_true;

    always_comb begin
        if (cond_true) begin
            redirect_o    = active && (!pred_taken_i || (pred_target_i != target));
            redirect_pc_o = target;
        end else begin
            redirect_o    = active && pred_taken_i;
            redirect_pc_o = link_pc_o;
        end
    end

endmodule

// File: hdl/ex_alu.sv
`timescale 1ns/100ps
module ex_alu import ex_pkg::*; #(
    parameter logic [XLEN-1:0] TID_VALUE = '0,
    parameter int              COUNTER_W = 64
) (
    input  logic            aclk,
    input  logic            aresetn,
    input  uop_ctrl_u       ctrl_i,
    input  logic [XLEN-1:0] rj_val_i,
    input  logic [XLEN-1:0] rk_val_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] imm_i,
    output logic [XLEN-1:0] result_o
);

    logic [COUNTER_W-1:0] stable_cnt;
    logic [XLEN-1:0]      src_a;
    logic [XLEN-1:0]      src_b;
    logic [4:0]           shamt;

    // free-running stable counter
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    always_comb begin
        case (ctrl_i.alu.src1)
            SRC1_REG:  src_a = rj_val_i;
            SRC1_PC:   src_a = pc_i;
            SRC1_ZERO: src_a = '0;
            default:   src_a = TID_VALUE;
        endcase
        case (ctrl_i.alu.src2)
            SRC2_REG:  src_b = rk_val_i;
            SRC2_IMM:  src_b = imm_i;
            SRC2_CNTL: src_b = stable_cnt[XLEN-1:0];
            // high word zero extended for narrow counters
            default:   src_b = XLEN'(stable_cnt >> 32);
        endcase
    end

    assign shamt = src_b[4:0];

    always_comb begin
        case (ctrl_i.alu.op)
            ALU_ADD:   result_o = src_a + src_b;
            ALU_SUB:   result_o = src_a - src_b;
            ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, src_a < src_b};
            ALU_AND:   result_o = src_a & src_b;
            ALU_OR:    result_o = src_a | src_b;
            ALU_XOR:   result_o = src_a ^ src_b;
            ALU_NOR:   result_o = ~(src_a | src_b);
            ALU_SLL:   result_o = src_a << shamt;
            ALU_SRL:   result_o = src_a >> shamt;
            ALU_SRA:   result_o = $unsigned($signed(src_a) >>> shamt);
            // immediate already positioned by decode
            ALU_LU12I: result_o = imm_i;
            default:   result_o = '0;
        endcase
    end

endmodule

// File: hdl/ex_forward.sv
`timescale 1ns/100ps
module ex_forward import ex_pkg::*; (
    input  logic [REG_AW-1:0] rs_i,
    input  logic [XLEN-1:0]   rf_data_i,
    input  logic              wb_valid_i,
    input  logic [REG_AW-1:0] wb_rd_i,
    input  logic [XLEN-1:0]   wb_data_i,
    output logic [XLEN-1:0]   data_o,
    output logic              fwd_o
);

    logic hit;

    // buffer entry targets the register this operand reads
    assign hit = wb_valid_i && (wb_rd_i == rs_i) && (rs_i != '0);

    assign fwd_o  = hit;
    assign data_o = hit ? wb_data_i : rf_data_i;

endmodule

// File: hdl/ex_regfile.sv
`timescale 1ns/100ps
module ex_regfile import ex_pkg::*; (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic [REG_AW-1:0] ra_i,
    input  logic [REG_AW-1:0] rb_i,
    output logic [XLEN-1:0]   rdata_a_o,
    output logic [XLEN-1:0]   rdata_b_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] wa_i,
    input  logic [XLEN-1:0]   wd_i
);

    logic [XLEN-1:0] regs [0:(1<<REG_AW)-1];

    // r0 reads zero and a same-cycle write is seen by the read
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && (wa_i == addr)) begin
            return wd_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < (1 << REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wa_i != '0)) begin
            regs[wa_i] <= wd_i;
        end
    end

    assign rdata_a_o = read_port(ra_i);
    assign rdata_b_o = read_port(rb_i);

endmodule

// File: hdl/ex_pkg.sv
package ex_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // micro-op class picks the view of the control byte
    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_ALU    = 2'd1,
        OP_BRANCH = 2'd2
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_XOR   = 4'd6,
        ALU_NOR   = 4'd7,
        ALU_SLL   = 4'd8,
        ALU_SRL   = 4'd9,
        ALU_SRA   = 4'd10,
        ALU_LU12I = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_REG  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2,
        SRC1_TID  = 2'd3
    } src1_sel_e;

    // counter words feed rdcntvl / rdcntvh
    typedef enum logic [1:0] {
        SRC2_REG  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_CNTL = 2'd2,
        SRC2_CNTH = 2'd3
    } src2_sel_e;

    typedef enum logic [2:0] {
        BR_EQ     = 3'd0,
        BR_NE     = 3'd1,
        BR_LT     = 3'd2,
        BR_GE     = 3'd3,
        BR_LTU    = 3'd4,
        BR_GEU    = 3'd5,
        BR_ALWAYS = 3'd6,
        BR_JIRL   = 3'd7
    } br_cond_e;

    // one control byte read as alu or branch fields depending on the class
    typedef union packed {
        struct packed {
            alu_op_e   op;
            src1_sel_e src1;
            src2_sel_e src2;
        } alu;
        struct packed {
            br_cond_e   cond;
            logic       link;
            logic [3:0] rsvd;
        } br;
    } uop_ctrl_u;

endpackage
